// ==== logic/dsi_tx_pkg.sv ====
package dsi_tx_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [15:0] crc_t;
  typedef logic [23:0] header_t;   // {word count, data id}
  typedef logic [7:0]  ecc_t;
  typedef logic [7:0]  data_id_t;
  typedef logic [15:0] count_t;
  typedef logic [2:0]  lanes_t;    // 1 to 4
  typedef logic [3:0]  strobe_t;

  typedef enum logic [1:0] {
    pkt_vss,
    pkt_hss,
    pkt_pixel_line
  } pkt_kind_t;

  typedef enum logic [3:0] {
    idle,
    send_vss,
    wait_vss,
    send_hss_vsa,
    wait_vsa,
    send_hss_vbp,
    wait_vbp,
    send_hss_act,
    wait_hbp,
    send_line,
    wait_hfp,
    send_hss_vfp,
    wait_vfp
  } seq_state_t;

  localparam data_id_t id_vss   = 8'h01;
  localparam data_id_t id_hss   = 8'h21;
  localparam data_id_t id_pps24 = 8'h3e;   // packed pixel stream, 24 bit

  localparam int fifo_depth = 4;

endpackage

// ==== logic/dsi_word_if.sv ====
`timescale 1ns/1ps

interface dsi_word_if;

  dsi_tx_pkg::word_t data;
  logic              half;    // only the low 2 bytes are meaningful
  logic              valid;
  logic              ready;

  modport source (
    output data, half, valid,
    input  ready
  );

  modport sink (
    input  data, half, valid,
    output ready
  );

endinterface

// ==== logic/dsi_ecc.sv ====
`timescale 1ns/1ps

module dsi_ecc (
  input  dsi_tx_pkg::header_t header,
  output dsi_tx_pkg::ecc_t    ecc
);

  // header bits covered by each parity bit
  localparam logic [23:0] parity_mask [6] = '{
    24'hf12cb7,
    24'hf2555b,
    24'h749a6d,
    24'hb8e38e,
    24'hdf03f0,
    24'heffc00
  };

  always_comb
  begin
    ecc = '0;                 // bits 7:6 stay zero
    for (int i = 0; i < 6; i++)
      ecc[i] = ^(header & parity_mask[i]);
  end

endmodule

// ==== logic/dsi_crc16.sv ====
`timescale 1ns/1ps

module dsi_crc16 (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              update,
  input  dsi_tx_pkg::word_t data,
  output dsi_tx_pkg::crc_t  crc
);

  // bit serial, lsb first, so byte 0 is folded in before byte 1
  function automatic dsi_tx_pkg::crc_t fold_word(dsi_tx_pkg::crc_t c, dsi_tx_pkg::word_t d);
    dsi_tx_pkg::crc_t r;
    r = c;
    for (int i = 0; i < 32; i++)
    begin
      if (r[0] ^ d[i])
        r = (r >> 1) ^ 16'h8408;
      else
        r = r >> 1;
    end
    return r;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      crc <= 16'hffff;
    else if (clear)
      crc <= 16'hffff;
    else if (update)
      crc <= fold_word(crc, data);
  end

endmodule

// ==== logic/dsi_frame_sequencer.sv ====
`timescale 1ns/1ps

module dsi_frame_sequencer #(
  parameter int blank_time = 6,
  parameter int hbp_time   = 3,
  parameter int vsa_lines  = 1,
  parameter int vbp_lines  = 1,
  parameter int act_lines  = 1,
  parameter int vfp_lines  = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  logic                  line_ready,
  output logic                  pkt_valid,
  output dsi_tx_pkg::pkt_kind_t pkt_kind,
  input  logic                  pkt_done
);

  dsi_tx_pkg::seq_state_t state;
  dsi_tx_pkg::seq_state_t state_next;
  dsi_tx_pkg::count_t     blank_cnt;
  dsi_tx_pkg::count_t     line_cnt;
  logic                   in_wait;
  logic                   wait_done;
  logic                   last_line;

  assign wait_done = in_wait && (blank_cnt == '0);
  assign last_line = (line_cnt == '0);

  always_comb
  begin
    pkt_valid = 1'b0;
    pkt_kind  = dsi_tx_pkg::pkt_hss;
    in_wait   = 1'b0;
    case (state)
      dsi_tx_pkg::idle:
        in_wait = 1'b0;
      dsi_tx_pkg::send_vss:
      begin
        pkt_valid = 1'b1;
        pkt_kind  = dsi_tx_pkg::pkt_vss;
      end
      dsi_tx_pkg::send_hss_vsa, dsi_tx_pkg::send_hss_vbp,
      dsi_tx_pkg::send_hss_act, dsi_tx_pkg::send_hss_vfp:
        pkt_valid = 1'b1;
      dsi_tx_pkg::send_line:
      begin
        pkt_valid = 1'b1;
        pkt_kind  = dsi_tx_pkg::pkt_pixel_line;
      end
      default:
        in_wait = 1'b1;           // every other state is a blanking wait
    endcase
  end

  always_comb
  begin
    state_next = state;
    case (state)
      dsi_tx_pkg::idle:
        if (enable && line_ready)
          state_next = dsi_tx_pkg::send_vss;
      dsi_tx_pkg::send_vss:
        if (pkt_done)
          state_next = dsi_tx_pkg::wait_vss;
      dsi_tx_pkg::wait_vss:
        if (wait_done)
          state_next = dsi_tx_pkg::send_hss_vsa;
      dsi_tx_pkg::send_hss_vsa:
        if (pkt_done)
          state_next = dsi_tx_pkg::wait_vsa;
      dsi_tx_pkg::wait_vsa:
        if (wait_done)
          state_next = last_line ? dsi_tx_pkg::send_hss_vbp : dsi_tx_pkg::send_hss_vsa;
      dsi_tx_pkg::send_hss_vbp:
        if (pkt_done)
          state_next = dsi_tx_pkg::wait_vbp;
      dsi_tx_pkg::wait_vbp:
        if (wait_done)
          state_next = last_line ? dsi_tx_pkg::send_hss_act : dsi_tx_pkg::send_hss_vbp;
      dsi_tx_pkg::send_hss_act:
        if (pkt_done)
          state_next = dsi_tx_pkg::wait_hbp;
      dsi_tx_pkg::wait_hbp:
        if (wait_done)
          state_next = dsi_tx_pkg::send_line;
      dsi_tx_pkg::send_line:
        if (pkt_done)
          state_next = dsi_tx_pkg::wait_hfp;
      dsi_tx_pkg::wait_hfp:
        if (wait_done)
          state_next = last_line ? dsi_tx_pkg::send_hss_vfp : dsi_tx_pkg::send_hss_act;
      dsi_tx_pkg::send_hss_vfp:
        if (pkt_done)
          state_next = dsi_tx_pkg::wait_vfp;
      dsi_tx_pkg::wait_vfp:
        if (wait_done)
          state_next = last_line ? dsi_tx_pkg::idle : dsi_tx_pkg::send_hss_vfp;
      default:
        state_next = dsi_tx_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= dsi_tx_pkg::idle;
    else
      state <= state_next;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      blank_cnt <= '0;
    else if (state != state_next)
      blank_cnt <= (state_next == dsi_tx_pkg::wait_hbp) ? dsi_tx_pkg::count_t'(hbp_time - 1)
                                                        : dsi_tx_pkg::count_t'(blank_time - 1);
    else if (blank_cnt != '0)
      blank_cnt <= blank_cnt - 1'b1;
  end

  // lines left in the current group, reloaded when the group changes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      line_cnt <= '0;
    else if (wait_done)
    begin
      case (state)
        dsi_tx_pkg::wait_vss:
          line_cnt <= dsi_tx_pkg::count_t'(vsa_lines - 1);
        dsi_tx_pkg::wait_vsa:
          line_cnt <= last_line ? dsi_tx_pkg::count_t'(vbp_lines - 1) : line_cnt - 1'b1;
        dsi_tx_pkg::wait_vbp:
          line_cnt <= last_line ? dsi_tx_pkg::count_t'(act_lines - 1) : line_cnt - 1'b1;
        dsi_tx_pkg::wait_hfp:
          line_cnt <= last_line ? dsi_tx_pkg::count_t'(vfp_lines - 1) : line_cnt - 1'b1;
        dsi_tx_pkg::wait_vfp:
          line_cnt <= last_line ? line_cnt : line_cnt - 1'b1;
        default:
          line_cnt <= line_cnt;   // hbp wait is mid-line
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) pkt_done |-> pkt_valid);

endmodule

// ==== logic/dsi_packet_builder.sv ====
`timescale 1ns/1ps

module dsi_packet_builder #(
  parameter int bytes_per_line = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pkt_valid,
  input  dsi_tx_pkg::pkt_kind_t pkt_kind,
  output logic                  pkt_done,
  input  dsi_tx_pkg::word_t     pix_data,
  input  logic                  pix_valid,
  output logic                  pix_ready,
  dsi_word_if.source            out
);

  typedef enum logic [1:0] {ph_header, ph_payload, ph_crc} phase_t;

  phase_t               phase;
  dsi_tx_pkg::data_id_t data_id;
  dsi_tx_pkg::count_t   word_count;
  dsi_tx_pkg::header_t  header;
  dsi_tx_pkg::ecc_t     ecc;
  dsi_tx_pkg::crc_t     crc;
  dsi_tx_pkg::count_t   words_left;
  logic                 is_line;
  logic                 out_fire;
  logic                 pix_fire;
  logic                 crc_clear;

  assign is_line    = (pkt_kind == dsi_tx_pkg::pkt_pixel_line);
  assign data_id    = (pkt_kind == dsi_tx_pkg::pkt_vss) ? dsi_tx_pkg::id_vss :
                      is_line ? dsi_tx_pkg::id_pps24 : dsi_tx_pkg::id_hss;
  assign word_count = is_line ? dsi_tx_pkg::count_t'(bytes_per_line) : '0;
  assign header     = {word_count, data_id};

  assign out_fire  = out.valid && out.ready;
  assign pix_fire  = pix_valid && pix_ready;
  assign crc_clear = out_fire && (phase == ph_header) && is_line;
  assign pkt_done  = out_fire && ((phase == ph_crc) || ((phase == ph_header) && !is_line));

  dsi_ecc i_ecc (
    .header (header),
    .ecc    (ecc)
  );

  dsi_crc16 i_crc16 (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (crc_clear),
    .update (pix_fire),
    .data   (pix_data),
    .crc    (crc)
  );

  always_comb
  begin
    out.valid = 1'b0;
    out.half  = 1'b0;
    out.data  = {ecc, header};
    pix_ready = 1'b0;
    case (phase)
      ph_header:
        out.valid = pkt_valid;
      ph_payload:
      begin
        out.valid = pix_valid;      // pixels pass straight through
        out.data  = pix_data;
        pix_ready = out.ready;
      end
      default:
      begin
        out.valid = 1'b1;
        out.half  = 1'b1;
        out.data  = {dsi_tx_pkg::half_t'(0), crc};
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase      <= ph_header;
      words_left <= '0;
    end
    else if (out_fire)
    begin
      case (phase)
        ph_header:
          if (is_line)
          begin
            phase      <= ph_payload;
            words_left <= dsi_tx_pkg::count_t'(bytes_per_line / 4);
          end
        ph_payload:
        begin
          words_left <= words_left - 1'b1;
          if (words_left == dsi_tx_pkg::count_t'(1))
            phase <= ph_crc;
        end
        default:
          phase <= ph_header;
      endcase
    end
  end

  // pixels are only pulled while the sequencer asks for a line
  assert property (@(posedge clk) disable iff (!rst_n)
    pix_ready |-> pkt_valid && is_line);

endmodule

// ==== logic/dsi_stream_fifo.sv ====
`timescale 1ns/1ps

module dsi_stream_fifo #(
  parameter int depth = dsi_tx_pkg::fifo_depth
) (
  input logic        clk,
  input logic        rst_n,
  dsi_word_if.sink   wr,
  dsi_word_if.source rd
);

  localparam int ptr_w = $clog2(depth);

  logic [32:0]      mem [depth];   // {half, data}
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             wr_fire;
  logic             rd_fire;

  assign wr.ready = (count != (ptr_w + 1)'(depth));
  assign rd.valid = (count != '0);
  assign {rd.half, rd.data} = mem[rd_ptr];   // show-ahead
  assign wr_fire  = wr.valid && wr.ready;
  assign rd_fire  = rd.valid && rd.ready;

  always_ff @(posedge clk)
  begin
    if (wr_fire)
      mem[wr_ptr] <= {wr.half, wr.data};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_fire)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_fire)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a stalled write holds its word
  assert property (@(posedge clk) disable iff (!rst_n)
    wr.valid && !wr.ready |=> wr.valid && $stable(wr.data) && $stable(wr.half));

endmodule

// ==== logic/dsi_lane_repacker.sv ====
`timescale 1ns/1ps

module dsi_lane_repacker (
  input  logic                clk,
  input  logic                rst_n,
  dsi_word_if.sink            in,
  input  dsi_tx_pkg::lanes_t  lanes_number,
  output dsi_tx_pkg::word_t   phy_data,
  output dsi_tx_pkg::strobe_t phy_write,
  input  dsi_tx_pkg::strobe_t phy_full
);

  logic [63:0]       shift_reg;     // oldest byte in bits 7:0
  logic [3:0]        byte_cnt;
  logic [3:0]        lanes;
  logic [3:0]        in_bytes;
  logic [3:0]        out_bytes;
  logic [3:0]        keep_bytes;
  logic [3:0]        free_bytes;
  logic [4:0]        strobe_wide;
  logic              emit;
  logic              take;
  dsi_tx_pkg::word_t in_word;

  assign lanes = {1'b0, lanes_number};

  // full lane width, or flush the tail once the fifo runs dry
  assign emit = !(|phy_full) &&
                ((byte_cnt >= lanes) || ((byte_cnt != '0) && !in.valid));
  assign out_bytes  = !emit ? 4'd0 : ((byte_cnt >= lanes) ? lanes : byte_cnt);
  assign keep_bytes = byte_cnt - out_bytes;
  assign free_bytes = 4'd8 - keep_bytes;

  assign in.ready = (free_bytes >= 4'd4);
  assign take     = in.valid && in.ready;
  assign in_bytes = in.half ? 4'd2 : 4'd4;
  assign in_word  = in.half ? {16'h0, in.data[15:0]} : in.data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_reg <= '0;
      byte_cnt  <= '0;
    end
    else
    begin
      shift_reg <= (shift_reg >> {out_bytes, 3'b000}) |
                   (take ? ({32'h0, in_word} << {keep_bytes, 3'b000}) : 64'h0);
      byte_cnt  <= keep_bytes + (take ? in_bytes : 4'd0);
    end
  end

  assign strobe_wide = (5'd1 << out_bytes) - 5'd1;
  assign phy_write   = strobe_wide[3:0];
  assign phy_data    = shift_reg[31:0];

  // zero lanes would never drain
  assert property (@(posedge clk) disable iff (!rst_n)
    lanes_number >= 3'd1 && lanes_number <= 3'd4);

endmodule

// ==== logic/dsi_tx_assembler.sv ====
`timescale 1ns/1ps

module dsi_tx_assembler #(
  parameter int bytes_per_line = 8,
  parameter int blank_time     = 6,
  parameter int hbp_time       = 3,
  parameter int vsa_lines      = 1,
  parameter int vbp_lines      = 1,
  parameter int act_lines      = 2,
  parameter int vfp_lines      = 1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  dsi_tx_pkg::word_t   pix_data,
  input  logic                pix_valid,
  output logic                pix_ready,
  input  logic                line_ready,
  input  logic                enable,
  input  dsi_tx_pkg::lanes_t  lanes_number,
  output dsi_tx_pkg::word_t   phy_data,
  output dsi_tx_pkg::strobe_t phy_write,
  input  dsi_tx_pkg::strobe_t phy_full
);

  logic                  pkt_valid;
  dsi_tx_pkg::pkt_kind_t pkt_kind;
  logic                  pkt_done;

  dsi_word_if build_if ();   // builder to fifo
  dsi_word_if lane_if ();    // fifo to repacker

  dsi_frame_sequencer #(
    .blank_time (blank_time),
    .hbp_time   (hbp_time),
    .vsa_lines  (vsa_lines),
    .vbp_lines  (vbp_lines),
    .act_lines  (act_lines),
    .vfp_lines  (vfp_lines)
  ) i_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .line_ready (line_ready),
    .pkt_valid  (pkt_valid),
    .pkt_kind   (pkt_kind),
    .pkt_done   (pkt_done)
  );

  dsi_packet_builder #(
    .bytes_per_line (bytes_per_line)
  ) i_builder (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_valid (pkt_valid),
    .pkt_kind  (pkt_kind),
    .pkt_done  (pkt_done),
    .pix_data  (pix_data),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .out       (build_if.source)
  );

  dsi_stream_fifo #(
    .depth (dsi_tx_pkg::fifo_depth)
  ) i_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (build_if.sink),
    .rd    (lane_if.source)
  );

  dsi_lane_repacker i_repacker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in           (lane_if.sink),
    .lanes_number (lanes_number),
    .phy_data     (phy_data),
    .phy_write    (phy_write),
    .phy_full     (phy_full)
  );

endmodule

// ==== tests/tb_dsi_tx_model.svh ====
`ifndef TB_DSI_TX_MODEL_SVH
`define TB_DSI_TX_MODEL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [7:0] pixel_byte(input int base, input int j);
  logic [7:0] b;
  b = 8'(4 * base + j);   // incrementing byte pattern
  return b;
endfunction

// hamming parity per the DSI header equations
function automatic logic [7:0] ref_ecc(input logic [23:0] d);
  logic [7:0] e;
  e = 8'h00;
  e[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
       ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
  e[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
       ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
  e[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
       ^ d[18] ^ d[20] ^ d[21] ^ d[22];
  e[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
       ^ d[19] ^ d[20] ^ d[21] ^ d[23];
  e[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
       ^ d[19] ^ d[20] ^ d[22] ^ d[23];
  e[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
       ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
  return e;
endfunction

function automatic logic [15:0] crc_byte(input logic [15:0] c, input logic [7:0] b);
  logic [15:0] r;
  r = c ^ {8'h00, b};
  for (int k = 0; k < 8; k++)
    r = r[0] ? ((r >> 1) ^ 16'h8408) : (r >> 1);
  return r;
endfunction

function automatic logic [15:0] ref_line_crc(input int base);
  logic [15:0] c;
  c = 16'hffff;
  for (int j = 0; j < bytes_per_line; j++)
    c = crc_byte(c, pixel_byte(base, j));
  return c;
endfunction

task automatic push_header(input logic [7:0] id, input logic [15:0] wc);
  expected.push_back(id);
  expected.push_back(wc[7:0]);
  expected.push_back(wc[15:8]);
  expected.push_back(ref_ecc({wc, id}));
endtask

task automatic build_frame(input int base);
  logic [15:0] crc;
  int          w;
  expected.delete();
  w = base;
  push_header(8'h01, 16'd0);            // vss
  repeat (vsa_lines + vbp_lines)
    push_header(8'h21, 16'd0);
  for (int l = 0; l < act_lines; l++)
  begin
    push_header(8'h21, 16'd0);
    push_header(8'h3e, 16'(bytes_per_line));
    for (int j = 0; j < bytes_per_line; j++)
      expected.push_back(pixel_byte(w, j));
    crc = ref_line_crc(w);
    expected.push_back(crc[7:0]);
    expected.push_back(crc[15:8]);
    w = w + bytes_per_line / 4;
  end
  repeat (vfp_lines)
    push_header(8'h21, 16'd0);
endtask

task automatic check(input string name, input logic [31:0] actual, input logic [31:0] want);
  if (actual !== want)
  begin
    $display("ERROR %s: got %h, expected %h", name, actual, want);
    errors++;
  end
endtask

`endif

// ==== tests/tb_dsi_tx_assembler.sv ====
`timescale 1ns/1ps

module tb_dsi_tx_assembler;

  localparam int bytes_per_line = 8;
  localparam int blank_time     = 6;
  localparam int hbp_time       = 3;
  localparam int vsa_lines      = 1;
  localparam int vbp_lines      = 1;
  localparam int act_lines      = 2;
  localparam int vfp_lines      = 1;
  localparam int wait_limit     = 3000;

  logic                clk;
  logic                rst_n;
  logic                enable;
  logic                line_ready;
  logic                pix_valid;
  logic                pix_ready;
  dsi_tx_pkg::word_t   pix_data;
  dsi_tx_pkg::word_t   phy_data;
  dsi_tx_pkg::lanes_t  lanes_number;
  dsi_tx_pkg::strobe_t phy_write;
  dsi_tx_pkg::strobe_t phy_full;

  logic [7:0]  collected [$];
  logic [7:0]  expected [$];
  logic [31:0] rand_state;
  int          errors;
  int          timeouts;
  int          pix_idx;       // index of the word on pix_data
  int          frame_base;
  bit          stall_phy;
  bit          drop_pix;

  `include "tb_dsi_tx_model.svh"

  dsi_tx_assembler #(
    .bytes_per_line (bytes_per_line),
    .blank_time     (blank_time),
    .hbp_time       (hbp_time),
    .vsa_lines      (vsa_lines),
    .vbp_lines      (vbp_lines),
    .act_lines      (act_lines),
    .vfp_lines      (vfp_lines)
  ) i_dsi_tx_assembler (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_data     (pix_data),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .line_ready   (line_ready),
    .enable       (enable),
    .lanes_number (lanes_number),
    .phy_data     (phy_data),
    .phy_write    (phy_write),
    .phy_full     (phy_full)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // pixel source and phy back-pressure
  always @(posedge clk)
  begin
    rand_state = lcg_next(rand_state);
    if (pix_valid && pix_ready)
      pix_idx = pix_idx + 1;
    pix_data <= {pixel_byte(pix_idx, 3), pixel_byte(pix_idx, 2),
                 pixel_byte(pix_idx, 1), pixel_byte(pix_idx, 0)};
    if (!pix_valid || pix_ready)
      pix_valid <= !drop_pix || rand_state[28];
    phy_full <= (stall_phy && rand_state[31:30] == 2'b00) ? rand_state[19:16] : 4'h0;
  end

  // phy sink, lane 0 holds the oldest byte
  always @(posedge clk)
  begin
    logic [3:0] mask_plus_one;
    logic [3:0] lane_mask;
    mask_plus_one = phy_write + 4'd1;
    lane_mask     = 4'((5'd1 << lanes_number) - 5'd1);
    if (rst_n)
    begin
      for (int i = 0; i < 4; i++)
        if (phy_write[i])
          collected.push_back(phy_data[8*i +: 8]);
      if (|phy_full)
        check("phy_write while phy_full", phy_write, 0);
      check("phy_write beyond lanes_number", phy_write & ~lane_mask, 0);
      check("phy_write contiguous", phy_write & mask_plus_one, 0);
    end
  end

  task automatic wait_for_bytes(input int n);
    int cycles;
    cycles = 0;
    while (collected.size() < n && cycles < wait_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (collected.size() < n)
    begin
      $display("timeout: only %0d of %0d frame bytes reached the phy", collected.size(), n);
      timeouts++;
    end
  endtask

  task automatic run_frame(input int lanes, input bit stall, input bit drop);
    @(posedge clk);
    lanes_number <= 3'(lanes);
    stall_phy = stall;
    drop_pix  = drop;
    collected.delete();
    frame_base = pix_idx;           // stable while the sequencer is idle
    build_frame(frame_base);
    enable <= 1'b1;
    @(posedge clk);
    enable <= 1'b0;
    wait_for_bytes(expected.size());
    repeat (20) @(posedge clk);     // quiet period, catches extra bytes
    check("stream length", collected.size(), expected.size());
    for (int i = 0; i < expected.size() && i < collected.size(); i++)
      check($sformatf("phy byte %0d", i), collected[i], expected[i]);
    stall_phy = 1'b0;
    drop_pix  = 1'b0;
  endtask

  task automatic idle_outputs_stay_low();
    repeat (50)
    begin
      @(posedge clk);
      check("phy_write", phy_write, 0);
      check("pix_ready", pix_ready, 0);
    end
  endtask

  task automatic frame_narrow_lanes();
    for (int n = 1; n <= 3; n++)
      run_frame(n, 1'b0, 1'b0);
  endtask

  task automatic frame_pixel_gaps();
    int offset;
    offset = 4 * (3 + vsa_lines + vbp_lines) + bytes_per_line;   // first line crc
    run_frame(4, 1'b0, 1'b1);
    if (collected.size() >= offset + 2)
      check("line crc", {collected[offset + 1], collected[offset]}, ref_line_crc(frame_base));
  endtask

  initial
  begin
    rst_n        = 1'b0;
    enable       = 1'b0;
    line_ready   = 1'b1;
    lanes_number = 3'd4;
    pix_data     = '0;
    pix_valid    = 1'b0;
    phy_full     = 4'h0;
    errors       = 0;
    timeouts     = 0;
    pix_idx      = 0;
    frame_base   = 0;
    stall_phy    = 1'b0;
    drop_pix     = 1'b0;
    rand_state   = 32'h17be_21b5;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    idle_outputs_stay_low();
    run_frame(4, 1'b0, 1'b0);
    frame_narrow_lanes();
    run_frame(4, 1'b1, 1'b0);       // random phy_full
    run_frame(2, 1'b1, 1'b0);
    frame_pixel_gaps();
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+tests
logic/dsi_tx_pkg.sv
logic/dsi_word_if.sv
logic/dsi_ecc.sv
logic/dsi_crc16.sv
logic/dsi_frame_sequencer.sv
logic/dsi_packet_builder.sv
logic/dsi_stream_fifo.sv
logic/dsi_lane_repacker.sv
logic/dsi_tx_assembler.sv
tests/tb_dsi_tx_assembler.sv
